/* src/fp16_fmt_pkg.sv */
// binary16 number format only; NaN payloads are never propagated
// RMM rounding is not supported by the 2-bit mode encoding
package fp16_fmt_pkg;

  // ------------------------------
  // Field geometry
  // ------------------------------
  localparam int unsigned EXP_BITS  = 5;
  localparam int unsigned MAN_BITS  = 10;
  localparam int unsigned BIAS      = 15;
  // Mantissa plus implicit bit
  localparam int unsigned PREC_BITS = MAN_BITS + 1;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp16_t;

  // Operand class, one-hot except is_signalling which qualifies is_nan
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_class_t;

  typedef enum logic [1:0] {
    RNE = 2'b00,
    RTZ = 2'b01,
    RDN = 2'b10,
    RUP = 2'b11
  } round_mode_e;

  // Exception flags, no divide-by-zero in an adder
  typedef struct packed {
    logic NV;
    logic OF;
    logic UF;
    logic NX;
  } fp_status_t;

  // Canonical quiet NaN, positive sign and MSB of mantissa set
  localparam fp16_t QNAN_CANON = 16'h7E00;

endpackage

/* src/fp16_add_path_pkg.sv */
// Internal widths of the add datapath, sized for binary16 operands
package fp16_add_path_pkg;

  // ------------------------------
  // Internal widths
  // ------------------------------
  // Signed exponent with room for carry-out and cancellation
  localparam int unsigned INT_EXP_BITS = fp16_fmt_pkg::EXP_BITS + 2;

  // Aligned field layout, MSB first
  // | carry | anchor mantissa (p) | guard and lower bits (2p+3) |
  localparam int unsigned SUM_BITS = 3 * fp16_fmt_pkg::PREC_BITS + 4;

  // Right shift of the addend saturates at SUM_BITS-1
  localparam int unsigned SHAMT_BITS = $clog2(SUM_BITS);

  // Count over the sum without its carry bit
  localparam int unsigned LZC_BITS = $clog2(SUM_BITS - 1);

  // ------------------------------
  // Types
  // ------------------------------
  typedef logic signed [INT_EXP_BITS-1:0] int_exp_t;

  typedef logic [SUM_BITS-1:0] sum_t;

  typedef logic [SHAMT_BITS-1:0] shamt_t;

endpackage

/* src/fp16_dec_exe_if.sv */
// Decode to execute bundle; fields are meaningful only while valid is high
interface fp16_dec_exe_if;
  import fp16_fmt_pkg::*;
  import fp16_add_path_pkg::*;

  logic                 valid;
  // Anchor (larger exponent) and addend mantissas, implicit bit included
  logic [PREC_BITS-1:0] mant_a;
  logic [PREC_BITS-1:0] mant_b;
  logic                 eff_sub;
  logic                 tent_sign;
  int_exp_t             tent_exp;
  int_exp_t             exp_diff;
  shamt_t               shamt;
  // Bypass result for NaN and infinity operands
  logic                 is_special;
  fp16_t                special_res;
  fp_status_t           special_stat;
  round_mode_e          rnd_mode;

  modport dec (output valid, mant_a, mant_b, eff_sub, tent_sign, tent_exp, exp_diff,
               shamt, is_special, special_res, special_stat, rnd_mode);
  modport exe (input valid, mant_a, mant_b, eff_sub, tent_sign, tent_exp, exp_diff,
               shamt, is_special, special_res, special_stat, rnd_mode);

endinterface

/* src/fp16_exe_res_if.sv */
// Execute to result bundle; fields are meaningful only while valid is high
interface fp16_exe_res_if;
  import fp16_fmt_pkg::*;
  import fp16_add_path_pkg::*;

  logic        valid;
  // Magnitude of the sum, anchor implicit bit at SUM_BITS-2
  sum_t        sum;
  // Addend bits lost below the aligned field
  logic        sticky;
  logic        final_sign;
  logic        eff_sub;
  int_exp_t    tent_exp;
  int_exp_t    exp_diff;
  shamt_t      shamt;
  logic        is_special;
  fp16_t       special_res;
  fp_status_t  special_stat;
  round_mode_e rnd_mode;

  modport exe (output valid, sum, sticky, final_sign, eff_sub, tent_exp, exp_diff, shamt,
               is_special, special_res, special_stat, rnd_mode);
  modport res (input valid, sum, sticky, final_sign, eff_sub, tent_exp, exp_diff, shamt,
               is_special, special_res, special_stat, rnd_mode);

endinterface

/* src/fp16_add_decode.sv */
// Stage 1 of 3; operands are captured only on a valid_i strobe
// Subnormals and zeros take internal exponent 1
module fp16_add_decode (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  fp16_fmt_pkg::fp16_t       a_i,
  input  fp16_fmt_pkg::fp16_t       b_i,
  input  fp16_fmt_pkg::round_mode_e rnd_mode_i,
  fp16_dec_exe_if.dec               dec_o
);
  import fp16_fmt_pkg::*;
  import fp16_add_path_pkg::*;

  function automatic fp_class_t classify(fp16_t x);
    fp_class_t c;
    logic      exp_zero;
    logic      exp_ones;
    logic      man_zero;
    exp_zero        = (x.exponent == '0);
    exp_ones        = (x.exponent == '1);
    man_zero        = (x.mantissa == '0);
    c.is_zero       = exp_zero & man_zero;
    c.is_subnormal  = exp_zero & ~man_zero;
    c.is_normal     = ~exp_zero & ~exp_ones;
    c.is_inf        = exp_ones & man_zero;
    c.is_nan        = exp_ones & ~man_zero;
    // Quiet bit is the mantissa MSB
    c.is_signalling = c.is_nan & ~x.mantissa[MAN_BITS-1];
    return c;
  endfunction

  fp_class_t   cls_a, cls_b;
  int_exp_t    exp_a, exp_b;
  logic        swap;
  logic        eff_sub;
  int_exp_t    exp_diff;
  shamt_t      shamt;
  logic        is_special;
  fp16_t       special_res;
  fp_status_t  special_stat;

  assign cls_a = classify(a_i);
  assign cls_b = classify(b_i);

  // Zero and subnormal both sit at the minimum exponent
  assign exp_a = (cls_a.is_zero | cls_a.is_subnormal) ? int_exp_t'(1)
                                                      : int_exp_t'({2'b00, a_i.exponent});
  assign exp_b = (cls_b.is_zero | cls_b.is_subnormal) ? int_exp_t'(1)
                                                      : int_exp_t'({2'b00, b_i.exponent});

  // ------------------------------
  // Operand ordering
  // ------------------------------
  // Larger exponent becomes the anchor and the other is shifted
  assign swap     = (exp_b > exp_a);
  assign eff_sub  = a_i.sign ^ b_i.sign;
  assign exp_diff = swap ? (exp_b - exp_a) : (exp_a - exp_b);
  // Saturate so the whole addend can land in the sticky region
  assign shamt    = (exp_diff > int_exp_t'(SUM_BITS - 1)) ? shamt_t'(SUM_BITS - 1)
                                                          : shamt_t'(exp_diff);

  // ------------------------------
  // Special cases
  // ------------------------------
  always_comb begin
    is_special   = 1'b0;
    special_res  = QNAN_CANON;
    special_stat = '0;
    if (cls_a.is_nan || cls_b.is_nan) begin
      is_special      = 1'b1;
      special_stat.NV = cls_a.is_signalling | cls_b.is_signalling;
    end else if (cls_a.is_inf || cls_b.is_inf) begin
      is_special = 1'b1;
      // inf - inf is invalid and keeps the canonical NaN
      if (cls_a.is_inf && cls_b.is_inf && eff_sub) begin
        special_stat.NV = 1'b1;
      end else if (cls_a.is_inf) begin
        special_res = '{sign: a_i.sign, exponent: '1, mantissa: '0};
      end else begin
        special_res = '{sign: b_i.sign, exponent: '1, mantissa: '0};
      end
    end
  end

  // Control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_o.valid <= 1'b0;
    end else begin
      dec_o.valid <= valid_i;
    end
  end

  // Payload registers load only with a strobe
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      dec_o.mant_a       <= swap ? {cls_b.is_normal, b_i.mantissa}
                                 : {cls_a.is_normal, a_i.mantissa};
      dec_o.mant_b       <= swap ? {cls_a.is_normal, a_i.mantissa}
                                 : {cls_b.is_normal, b_i.mantissa};
      dec_o.eff_sub      <= eff_sub;
      dec_o.tent_sign    <= swap ? b_i.sign : a_i.sign;
      dec_o.tent_exp     <= swap ? exp_b : exp_a;
      dec_o.exp_diff     <= exp_diff;
      dec_o.shamt        <= shamt;
      dec_o.is_special   <= is_special;
      dec_o.special_res  <= special_res;
      dec_o.special_stat <= special_stat;
      dec_o.rnd_mode     <= rnd_mode_i;
    end
  end

endmodule

/* src/fp16_add_execute.sv */
// Stage 2 of 3; the sum leaves as a magnitude with its sign fixed separately
module fp16_add_execute (
  input  logic        clk_i,
  input  logic        rst_n_i,
  fp16_dec_exe_if.exe dec_i,
  fp16_exe_res_if.exe exe_o
);
  import fp16_fmt_pkg::*;
  import fp16_add_path_pkg::*;

  sum_t                          anchor;
  logic [SUM_BITS+PREC_BITS-1:0] addend_wide;
  sum_t                          addend_al;
  logic [PREC_BITS-1:0]          addend_lost;
  logic                          sticky;
  sum_t                          addend_op;
  logic                          carry_in;
  logic [SUM_BITS:0]             sum_raw;
  logic                          carry;
  sum_t                          sum;
  logic                          final_sign;

  // ------------------------------
  // Alignment
  // ------------------------------
  // Anchor implicit bit just under the carry position
  assign anchor = {1'b0, dec_i.mant_a, {(SUM_BITS - 1 - PREC_BITS){1'b0}}};

  // Addend starts at the anchor position, p extra bits catch what falls out
  assign addend_wide = {1'b0, dec_i.mant_b, {(SUM_BITS - 1){1'b0}}} >> dec_i.shamt;
  assign {addend_al, addend_lost} = addend_wide;
  assign sticky = |addend_lost;

  // One's complement, +1 only when nothing below the field was dropped
  assign addend_op = dec_i.eff_sub ? ~addend_al : addend_al;
  assign carry_in  = dec_i.eff_sub & ~sticky;

  // ------------------------------
  // Adder
  // ------------------------------
  assign sum_raw = {1'b0, anchor} + {1'b0, addend_op} + (SUM_BITS + 1)'(carry_in);
  assign carry   = sum_raw[SUM_BITS];

  // No carry out of a subtraction means the addend was larger
  assign sum = (dec_i.eff_sub && !carry) ? -sum_raw[SUM_BITS-1:0] : sum_raw[SUM_BITS-1:0];

  // Flip the anchor sign when the subtraction went negative
  assign final_sign = (dec_i.eff_sub && !carry) ? ~dec_i.tent_sign : dec_i.tent_sign;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exe_o.valid <= 1'b0;
    end else begin
      exe_o.valid <= dec_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_i.valid) begin
      exe_o.sum          <= sum;
      exe_o.sticky       <= sticky;
      exe_o.final_sign   <= final_sign;
      exe_o.eff_sub      <= dec_i.eff_sub;
      exe_o.tent_exp     <= dec_i.tent_exp;
      exe_o.exp_diff     <= dec_i.exp_diff;
      exe_o.shamt        <= dec_i.shamt;
      exe_o.is_special   <= dec_i.is_special;
      exe_o.special_res  <= dec_i.special_res;
      exe_o.special_stat <= dec_i.special_stat;
      exe_o.rnd_mode     <= dec_i.rnd_mode;
    end
  end

endmodule

/* src/fp16_add_result.sv */
// Stage 3 of 3; underflow uses tininess after rounding and needs an inexact result
// Overflow under RTZ, or toward zero for its sign, saturates to the largest normal
module fp16_add_result (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  fp16_exe_res_if.res              exe_i,
  output logic                     valid_o,
  output fp16_fmt_pkg::fp16_t      result_o,
  output fp16_fmt_pkg::fp_status_t status_o
);
  import fp16_fmt_pkg::*;
  import fp16_add_path_pkg::*;

  logic [LZC_BITS-1:0]           lz;
  logic                          near;
  logic                          far_shift;
  int_exp_t                      shift_req;
  shamt_t                        norm_shamt;
  int_exp_t                      exp_n;
  sum_t                          shifted;
  int_exp_t                      exp_f;
  logic [MAN_BITS-1:0]           man_f;
  logic                          rnd_bit, stk_bit;
  logic                          of_pre;
  logic [EXP_BITS+MAN_BITS-1:0]  pre_abs, rounded_abs;
  logic [1:0]                    rs_bits;
  logic                          round_up;
  logic                          res_sign;
  fp16_t                         reg_res;
  fp_status_t                    reg_stat;

  // ------------------------------
  // Normalization
  // ------------------------------
  // Leading zeros below the carry bit, all zeros gives SUM_BITS-1
  always_comb begin
    lz = LZC_BITS'(SUM_BITS - 1);
    for (int i = 0; i < SUM_BITS - 1; i++) begin
      if (exe_i.sum[i]) lz = LZC_BITS'(SUM_BITS - 2 - i);
    end
  end

  // Massive cancellation only for close operands under subtraction
  assign near = exe_i.eff_sub && (exe_i.exp_diff < int_exp_t'(2));
  // Far subtraction loses at most one leading bit
  assign far_shift = (exe_i.shamt != '0) & ~exe_i.sum[SUM_BITS-1] & ~exe_i.sum[SUM_BITS-2];
  assign shift_req = near ? int_exp_t'({1'b0, lz}) : int_exp_t'({6'd0, far_shift});

  // Clamp so the exponent never drops below the subnormal level
  always_comb begin
    if (exe_i.tent_exp - shift_req >= int_exp_t'(1)) begin
      norm_shamt = shamt_t'(shift_req);
    end else begin
      norm_shamt = shamt_t'(exe_i.tent_exp - int_exp_t'(1));
    end
  end

  assign exp_n   = exe_i.tent_exp - int_exp_t'({1'b0, norm_shamt});
  assign shifted = exe_i.sum << norm_shamt;

  // One-bit correction for a carry out of the addition
  always_comb begin
    if (shifted[SUM_BITS-1]) begin
      exp_f   = exp_n + int_exp_t'(1);
      man_f   = shifted[SUM_BITS-2 -: MAN_BITS];
      rnd_bit = shifted[SUM_BITS-2-MAN_BITS];
      stk_bit = (|shifted[SUM_BITS-3-MAN_BITS:0]) | exe_i.sticky;
    end else begin
      // Leading one at the implicit position, or none for a subnormal
      exp_f   = shifted[SUM_BITS-2] ? exp_n : int_exp_t'(0);
      man_f   = shifted[SUM_BITS-3 -: MAN_BITS];
      rnd_bit = shifted[SUM_BITS-3-MAN_BITS];
      stk_bit = (|shifted[SUM_BITS-4-MAN_BITS:0]) | exe_i.sticky;
    end
  end

  // ------------------------------
  // Rounding
  // ------------------------------
  // Above the largest finite exponent
  assign of_pre  = exp_f > int_exp_t'(2 * BIAS);
  assign pre_abs = of_pre ? {EXP_BITS'(2 * BIAS), {MAN_BITS{1'b1}}}
                          : {exp_f[EXP_BITS-1:0], man_f};
  assign rs_bits = of_pre ? 2'b11 : {rnd_bit, stk_bit};

  always_comb begin
    unique case (exe_i.rnd_mode)
      RNE: round_up = rs_bits[1] & (rs_bits[0] | pre_abs[0]);
      RTZ: round_up = 1'b0;
      RDN: round_up = (|rs_bits) & exe_i.final_sign;
      RUP: round_up = (|rs_bits) & ~exe_i.final_sign;
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent, max normal rounds to inf
  assign rounded_abs = pre_abs + (EXP_BITS + MAN_BITS)'(round_up);

  // Exact zero from a subtraction is +0, except -0 rounding down
  assign res_sign = (exe_i.eff_sub && rounded_abs == '0) ? (exe_i.rnd_mode == RDN)
                                                          : exe_i.final_sign;

  assign reg_res     = {res_sign, rounded_abs};
  assign reg_stat.NV = 1'b0;
  assign reg_stat.OF = of_pre | (rounded_abs[EXP_BITS+MAN_BITS-1 -: EXP_BITS] == '1);
  assign reg_stat.NX = (|rs_bits) | reg_stat.OF;
  // Tiny after rounding means the exponent field stayed zero
  assign reg_stat.UF = reg_stat.NX & (rounded_abs[EXP_BITS+MAN_BITS-1 -: EXP_BITS] == '0);

  // ------------------------------
  // Output register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= exe_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exe_i.valid) begin
      result_o <= exe_i.is_special ? exe_i.special_res : reg_res;
      status_o <= exe_i.is_special ? exe_i.special_stat : reg_stat;
    end
  end

endmodule

/* src/fp16_add_top.sv */
// Fixed 3-cycle latency, one operation per cycle, no back-pressure
// Subtract by flipping the sign of b before the strobe
module fp16_add_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  fp16_fmt_pkg::fp16_t       a_i,
  input  fp16_fmt_pkg::fp16_t       b_i,
  input  fp16_fmt_pkg::round_mode_e rnd_mode_i,
  output logic                      valid_o,
  output fp16_fmt_pkg::fp16_t       result_o,
  output fp16_fmt_pkg::fp_status_t  status_o
);

  // Stage links
  fp16_dec_exe_if dec_exe ();
  fp16_exe_res_if exe_res ();

  fp16_add_decode u_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .rnd_mode_i (rnd_mode_i),
    .dec_o      (dec_exe.dec)
  );

  fp16_add_execute u_execute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dec_i   (dec_exe.exe),
    .exe_o   (exe_res.exe)
  );

  fp16_add_result u_result (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .exe_i    (exe_res.res),
    .valid_o  (valid_o),
    .result_o (result_o),
    .status_o (status_o)
  );

endmodule

/* sim/tb_fp16_add.sv */
// Directed testbench, relies on the fixed 3-cycle latency of the adder
// Expected results come in order from a queue filled by the stimulus tasks
module tb_fp16_add;
  import fp16_fmt_pkg::*;

  localparam int EXACT_OPS      = 64;
  localparam int TOTAL_OPS      = EXACT_OPS + 16 + 12 + 3 + 5;
  // One operation per cycle plus reset, fill and drain
  localparam int TIMEOUT_CYCLES = TOTAL_OPS + 40;
  localparam int LATENCY        = 3;

  localparam fp_status_t ST_NONE = 4'b0000;
  localparam fp_status_t ST_NX   = 4'b0001;
  localparam fp_status_t ST_OFNX = 4'b0101;
  localparam fp_status_t ST_NV   = 4'b1000;

  logic        clk_i;
  logic        rst_n_i;
  logic        valid_i;
  fp16_t       a_i;
  fp16_t       b_i;
  round_mode_e rnd_mode_i;
  logic        valid_o;
  fp16_t       result_o;
  fp_status_t  status_o;

  // Pending operations, oldest first
  fp16_t       exp_res_q[$];
  fp_status_t  exp_stat_q[$];
  int          issue_q[$];
  int          cycle = 0;
  logic [31:0] lfsr;

  fp16_add_top DUT (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .rnd_mode_i (rnd_mode_i),
    .valid_o    (valid_o),
    .result_o   (result_o),
    .status_o   (status_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  always @(posedge clk_i) begin
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, results stopped arriving", cycle);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Integers below 2048 in magnitude fit binary16 exactly
  function automatic fp16_t int_to_fp16(input int v);
    fp16_t r;
    int    m;
    int    e;
    r      = '0;
    m      = (v < 0) ? -v : v;
    r.sign = (v < 0);
    if (m != 0) begin
      e = 0;
      for (int k = 0; k < 11; k++) begin
        if (m[k]) e = k;
      end
      r.exponent = 5'(e + BIAS);
      // Leading one lands on the hidden bit and is dropped
      r.mantissa = 10'(m << (MAN_BITS - e));
    end
    return r;
  endfunction

  task automatic compare_fp16(input string name, input fp16_t got, input fp16_t expected);
    if (got !== expected) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_status(input string name, input fp_status_t got,
                                input fp_status_t expected);
    if (got !== expected) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, expected);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Entered one unit after a rising edge, returns at the same point a cycle later
  task automatic issue(input fp16_t a, input fp16_t b, input round_mode_e mode,
                       input fp16_t res, input fp_status_t stat);
    valid_i    = 1'b1;
    a_i        = a;
    b_i        = b;
    rnd_mode_i = mode;
    exp_res_q.push_back(res);
    exp_stat_q.push_back(stat);
    issue_q.push_back(cycle);
    @(posedge clk_i);
    #1;
  endtask

  // ------------------------------
  // Result checker
  // ------------------------------
  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (valid_o === 1'b1) begin
      if (issue_q.size() == 0) begin
        $display("Result at %0t arrived with no operation pending", $time);
        $display("TB FAILED");
        $fatal(1);
      end else if (cycle - issue_q[0] != LATENCY) begin
        $display("Result at %0t came %0d cycles after its input", $time, cycle - issue_q[0]);
        $display("TB FAILED");
        $fatal(1);
      end else begin
        compare_fp16("result_o", result_o, exp_res_q.pop_front());
        compare_status("status_o", status_o, exp_stat_q.pop_front());
        void'(issue_q.pop_front());
      end
    end else if (issue_q.size() != 0 && cycle - issue_q[0] >= LATENCY) begin
      $display("No result %0d cycles after the input of cycle %0d", LATENCY, issue_q[0]);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  // ------------------------------
  // Tests
  // ------------------------------
  // Back to back integer sums, also the pipelining test
  task automatic test_exact_sums();
    logic [31:0] v;
    int          x, y, s;
    round_mode_e mode;
    fp16_t       expected;
    for (int i = 0; i < EXACT_OPS; i++) begin
      mode = round_mode_e'(i[1:0]);
      take_bits(11, v);
      x = v[10] ? -int'(v[9:0]) : int'(v[9:0]);
      take_bits(11, v);
      y = v[10] ? -int'(v[9:0]) : int'(v[9:0]);
      s = x + y;
      expected = int_to_fp16(s);
      // Cancellation gives -0 only when rounding down
      if (s == 0 && x != 0 && mode == RDN) expected = 16'h8000;
      issue(int_to_fp16(x), int_to_fp16(y), mode, expected, ST_NONE);
    end
  endtask

  task automatic test_rounding();
    round_mode_e mode;
    for (int i = 0; i < 4; i++) begin
      mode = round_mode_e'(i[1:0]);
      // 1 + half ulp, a tie with an even lower neighbour
      issue(16'h3C00, 16'h1000, mode, (mode == RUP) ? 16'h3C01 : 16'h3C00, ST_NX);
      // 1 + 1.5 ulp, the tie goes up to the even 0x3C02
      issue(16'h3C00, 16'h1600, mode,
            (mode == RNE || mode == RUP) ? 16'h3C02 : 16'h3C01, ST_NX);
      // Lands on the finer grid below 1.0, so exact
      issue(16'h3C00, 16'h9000, mode, 16'h3BFF, ST_NONE);
      // Half a fine ulp below 1.0, tie between 0x3BFF and 1.0
      issue(16'h3C00, 16'h8C00, mode,
            (mode == RNE || mode == RUP) ? 16'h3C00 : 16'h3BFF, ST_NX);
    end
  endtask

  task automatic test_overflow_zero();
    round_mode_e mode;
    logic        sat_pos, sat_neg;
    for (int i = 0; i < 4; i++) begin
      mode = round_mode_e'(i[1:0]);
      // Saturate when the mode points toward zero for that sign
      sat_pos = (mode == RTZ || mode == RDN);
      sat_neg = (mode == RTZ || mode == RUP);
      issue(16'h7BFF, 16'h7BFF, mode, sat_pos ? 16'h7BFF : 16'h7C00, ST_OFNX);
      issue(16'hFBFF, 16'hFBFF, mode, sat_neg ? 16'hFBFF : 16'hFC00, ST_OFNX);
      issue(16'h4248, 16'hC248, mode, (mode == RDN) ? 16'h8000 : 16'h0000, ST_NONE);
    end
  endtask

  task automatic test_subnormals();
    issue(16'h0003, 16'h0005, RNE, 16'h0008, ST_NONE);
    // Carry into the smallest normal
    issue(16'h0200, 16'h0200, RNE, 16'h0400, ST_NONE);
    issue(16'h0400, 16'h8001, RDN, 16'h03FF, ST_NONE);
  endtask

  task automatic test_specials();
    // Quiet NaN with a payload, signalling NaN, then inf - inf
    issue(16'h7E55, 16'h3C00, RNE, QNAN_CANON, ST_NONE);
    issue(16'h3C00, 16'h7C01, RNE, QNAN_CANON, ST_NV);
    issue(16'h7C00, 16'hFC00, RNE, QNAN_CANON, ST_NV);
    issue(16'h3C00, 16'hFC00, RUP, 16'hFC00, ST_NONE);
    issue(16'h7C00, 16'h4000, RDN, 16'h7C00, ST_NONE);
  endtask

  initial begin
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    valid_i    = 1'b0;
    a_i        = '0;
    b_i        = '0;
    rnd_mode_i = RNE;
    lfsr       = 32'h9cf8;
    repeat (10) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #1;
    test_exact_sums();
    test_rounding();
    test_overflow_zero();
    test_subnormals();
    test_specials();
    valid_i = 1'b0;
    // Fixed latency bounds the drain
    for (int i = 0; i <= LATENCY && issue_q.size() != 0; i++) begin
      @(posedge clk_i);
    end
    if (issue_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d results never arrived", issue_q.size());
      $display("TB FAILED");
      $fatal(1);
    end
  end

endmodule

/* fp16_add_top.f */
src/fp16_fmt_pkg.sv
src/fp16_add_path_pkg.sv
src/fp16_dec_exe_if.sv
src/fp16_exe_res_if.sv
src/fp16_add_decode.sv
src/fp16_add_execute.sv
src/fp16_add_result.sv
src/fp16_add_top.sv
sim/tb_fp16_add.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_fp16_add
FILELIST   := fp16_add_top.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --Mdir $(OBJ_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
